// ==== cpu_defines.svh ====
// CPU width and size definitions
// shared by the package and by every stage of the five-stage CPU

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data word and instruction word
`define CPU_WORD_WIDTH 16

// instruction and data memory address
`define CPU_ADDR_WIDTH 8

// opcode field, instruction bits 15 to 11
`define CPU_OP_WIDTH 5

// general register file
`define CPU_NUM_REGS 8
`define CPU_REG_IDX_WIDTH 3

// shift amount and short immediate, instruction bits 3 to 0
`define CPU_SHAMT_WIDTH 4

`endif

// ==== cpu_pkg.sv ====
// CPU package
// word, address, instruction, opcode and run-state types, plus
// field helpers for the overlapping instruction fields

package cpu_pkg;

    `include "cpu_defines.svh"

    typedef logic [`CPU_WORD_WIDTH-1:0]    word_t;
    typedef logic [`CPU_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`CPU_REG_IDX_WIDTH-1:0] reg_idx_t;

    // project encodings, counted from zero
    typedef enum logic [`CPU_OP_WIDTH-1:0] {
        OP_NOP, OP_HALT, OP_LOAD, OP_STORE, OP_LDIH,
        OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_CMP,
        OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
        OP_JUMP, OP_JMPR, OP_BZ, OP_BNZ, OP_BN, OP_BNN
    } opcode_t;

    localparam int IMM_WIDTH = `CPU_WORD_WIDTH - `CPU_OP_WIDTH - `CPU_REG_IDX_WIDTH;

    // r2, r3, val2 and val3 all live inside imm
    typedef struct packed {
        opcode_t                op;
        reg_idx_t               r1;
        logic [IMM_WIDTH-1:0]   imm;
    } instr_t;

    typedef enum logic {ST_IDLE, ST_EXEC} run_state_t;

    localparam instr_t NOP_INSTR = '{op: OP_NOP, r1: '0, imm: '0};

    // r2 is bits 6 to 4
    function automatic reg_idx_t instr_r2(instr_t ir);
        return ir.imm[6:4];
    endfunction

    // r3 is bits 2 to 0
    function automatic reg_idx_t instr_r3(instr_t ir);
        return ir.imm[2:0];
    endfunction

    function automatic logic [`CPU_SHAMT_WIDTH-1:0] instr_val3(instr_t ir);
        return ir.imm[`CPU_SHAMT_WIDTH-1:0];
    endfunction

endpackage

// ==== cpu_run_control.sv ====
// CPU run controller
// two-state idle/exec machine; start while enabled begins execution,
// enable low or a retired HALT returns to idle

`timescale 1ns/100ps

module cpu_run_control
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    input  logic   start,
    input  instr_t wb_ir,
    output logic   advance
);

    run_state_t state;
    run_state_t next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (enable && start)
                    next_state = ST_EXEC;
            end
            ST_EXEC:
            begin
                // HALT stops the machine once it reaches write-back
                if (!enable || (wb_ir.op == OP_HALT))
                    next_state = ST_IDLE;
            end
            default:
            begin
                next_state = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    assign advance = (state == ST_EXEC);

endmodule

// ==== cpu_fetch.sv ====
// CPU fetch stage
// program counter and fetch register; a taken branch from the memory
// stage redirects the PC, otherwise it steps by one word

`timescale 1ns/100ps

module cpu_fetch
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   advance,
    input  instr_t i_datain,
    input  logic   branch_taken,
    input  addr_t  branch_target,
    output addr_t  i_addr,
    output instr_t id_ir
);

    addr_t pc;

    assign i_addr = pc;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc    <= '0;
            id_ir <= NOP_INSTR;
        end
        else if (advance)
        begin
            id_ir <= i_datain;
            // instructions already fetched behind the branch still run
            if (branch_taken)
                pc <= branch_target;
            else
                pc <= pc + addr_t'(1);
        end
    end

endmodule

// ==== cpu_reg_file.sv ====
// CPU general register file
// eight words, three combinational read ports, one write port that
// lands on the rising edge

`timescale 1ns/100ps

module cpu_reg_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_1,
    input  reg_idx_t rd_idx_2,
    input  reg_idx_t rd_idx_3,
    output word_t    rd_data_1,
    output word_t    rd_data_2,
    output word_t    rd_data_3,
    input  logic     wb_en,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data
);

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
        begin
            regs[wb_idx] <= wb_data;
        end
    end

    // no bypass, a write is visible from the next cycle
    assign rd_data_1 = regs[rd_idx_1];
    assign rd_data_2 = regs[rd_idx_2];
    assign rd_data_3 = regs[rd_idx_3];

endmodule

// ==== cpu_decode.sv ====
// CPU decode stage
// reads the register file, picks the A and B operands and the store
// data, and holds them in the decode-to-execute registers

`timescale 1ns/100ps

module cpu_decode
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  instr_t   id_ir,
    output reg_idx_t rd_idx_1,
    output reg_idx_t rd_idx_2,
    output reg_idx_t rd_idx_3,
    input  word_t    rd_data_1,
    input  word_t    rd_data_2,
    input  word_t    rd_data_3,
    output instr_t   ex_ir,
    output word_t    op_a,
    output word_t    op_b,
    output word_t    store_data
);

    opcode_t op;

    assign op       = id_ir.op;
    assign rd_idx_1 = id_ir.r1;
    assign rd_idx_2 = instr_r2(id_ir);
    assign rd_idx_3 = instr_r3(id_ir);

    // ------------------------------------------------------------------------
    // decode-to-execute registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_ir      <= NOP_INSTR;
            op_a       <= '0;
            op_b       <= '0;
            store_data <= '0;
        end
        else if (advance)
        begin
            ex_ir <= id_ir;

            if (op == OP_STORE)
                store_data <= rd_data_1;

            // operand A
            case (op)
                OP_JUMP:
                    op_a <= '0;
                OP_LDIH, OP_ADDI, OP_SUBI, OP_JMPR,
                OP_BZ, OP_BNZ, OP_BN, OP_BNN:
                    op_a <= rd_data_1;
                OP_LOAD, OP_STORE, OP_ADD, OP_SUB, OP_CMP,
                OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL:
                    op_a <= rd_data_2;
                default:
                    op_a <= op_a;
            endcase

            // operand B
            case (op)
                OP_LOAD, OP_STORE, OP_SLL, OP_SRL:
                    op_b <= word_t'(instr_val3(id_ir));
                OP_ADDI, OP_SUBI, OP_JUMP, OP_JMPR,
                OP_BZ, OP_BNZ, OP_BN, OP_BNN:
                    op_b <= word_t'(id_ir.imm);
                OP_LDIH:
                    op_b <= {id_ir.imm, {(`CPU_WORD_WIDTH - IMM_WIDTH){1'b0}}};
                OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_OR, OP_XOR:
                    op_b <= rd_data_3;
                default:
                    op_b <= op_b;
            endcase
        end
    end

endmodule

// ==== cpu_execute.sv ====
// CPU execute stage
// ALU and zero/negative flags, the execute-to-memory registers, and
// the branch decision taken while the branch sits in the memory stage

`timescale 1ns/100ps

module cpu_execute
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   advance,
    input  instr_t ex_ir,
    input  word_t  op_a,
    input  word_t  op_b,
    input  word_t  store_data,
    output instr_t mem_ir,
    output word_t  alu_result,
    output logic   mem_we,
    output word_t  mem_store_data,
    output logic   branch_taken,
    output addr_t  branch_target
);

    word_t alu_out;
    logic  sets_flags;
    logic  zf;
    logic  nf;

    always_comb
    begin
        case (ex_ir.op)
            OP_AND:                  alu_out = op_a & op_b;
            OP_OR:                   alu_out = op_a | op_b;
            OP_XOR:                  alu_out = op_a ^ op_b;
            OP_SLL:                  alu_out = op_a << op_b[`CPU_SHAMT_WIDTH-1:0];
            OP_SRL:                  alu_out = op_a >> op_b[`CPU_SHAMT_WIDTH-1:0];
            OP_SUB, OP_SUBI, OP_CMP: alu_out = op_a - op_b;
            // LDIH, memory address and branch target all add
            default:                 alu_out = op_a + op_b;
        endcase
    end

    always_comb
    begin
        case (ex_ir.op)
            OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_CMP,
            OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL:
                sets_flags = 1'b1;
            default:
                sets_flags = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // execute-to-memory registers and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_ir         <= NOP_INSTR;
            alu_result     <= '0;
            mem_we         <= 1'b0;
            mem_store_data <= '0;
            zf             <= 1'b0;
            nf             <= 1'b0;
        end
        else if (advance)
        begin
            mem_ir     <= ex_ir;
            alu_result <= alu_out;
            mem_we     <= (ex_ir.op == OP_STORE);
            if (ex_ir.op == OP_STORE)
                mem_store_data <= store_data;
            if (sets_flags)
            begin
                zf <= (alu_out == '0);
                nf <= alu_out[`CPU_WORD_WIDTH-1];
            end
        end
    end

    // branch resolved in the memory stage
    always_comb
    begin
        case (mem_ir.op)
            OP_JUMP, OP_JMPR: branch_taken = 1'b1;
            OP_BZ:            branch_taken = zf;
            OP_BNZ:           branch_taken = !zf;
            OP_BN:            branch_taken = nf;
            OP_BNN:           branch_taken = !nf;
            default:          branch_taken = 1'b0;
        endcase
    end

    assign branch_target = alu_result[`CPU_ADDR_WIDTH-1:0];

endmodule

// ==== cpu_mem_wb.sv ====
// CPU memory and write-back stage
// selects load data or the ALU result into the write-back register
// and raises the register-file write request

`timescale 1ns/100ps

module cpu_mem_wb
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     advance,
    input  instr_t   mem_ir,
    input  word_t    alu_result,
    input  word_t    d_datain,
    output instr_t   wb_ir,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output word_t    wb_data
);

    logic writes_reg;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_ir   <= NOP_INSTR;
            wb_data <= '0;
        end
        else if (advance)
        begin
            wb_ir <= mem_ir;
            if (mem_ir.op == OP_LOAD)
                wb_data <= d_datain;
            else
                wb_data <= alu_result;
        end
    end

    // CMP only sets flags
    always_comb
    begin
        case (wb_ir.op)
            OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
            OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase
    end

    assign wb_en  = advance && writes_reg;
    assign wb_idx = wb_ir.r1;

endmodule

// ==== pipe_cpu.sv ====
// five-stage pipelined 16-bit CPU
// fetch, decode, execute, memory and write-back with separate
// instruction and data memory ports; no forwarding or hazard checks

`timescale 1ns/100ps

module pipe_cpu
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,
    input  logic   start,
    input  instr_t i_datain,
    input  word_t  d_datain,
    output addr_t  i_addr,
    output addr_t  d_addr,
    output logic   d_we,
    output word_t  d_dataout
);

    logic     advance;
    instr_t   id_ir;
    instr_t   ex_ir;
    instr_t   mem_ir;
    instr_t   wb_ir;
    word_t    op_a;
    word_t    op_b;
    word_t    store_data;
    word_t    alu_result;
    logic     mem_we;
    word_t    mem_store_data;
    logic     branch_taken;
    addr_t    branch_target;
    reg_idx_t rd_idx_1;
    reg_idx_t rd_idx_2;
    reg_idx_t rd_idx_3;
    word_t    rd_data_1;
    word_t    rd_data_2;
    word_t    rd_data_3;
    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    cpu_run_control u_run_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .start   (start),
        .wb_ir   (wb_ir),
        .advance (advance)
    );

    cpu_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance       (advance),
        .i_datain      (i_datain),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .i_addr        (i_addr),
        .id_ir         (id_ir)
    );

    cpu_reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_idx_3  (rd_idx_3),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .rd_data_3 (rd_data_3),
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    cpu_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .id_ir      (id_ir),
        .rd_idx_1   (rd_idx_1),
        .rd_idx_2   (rd_idx_2),
        .rd_idx_3   (rd_idx_3),
        .rd_data_1  (rd_data_1),
        .rd_data_2  (rd_data_2),
        .rd_data_3  (rd_data_3),
        .ex_ir      (ex_ir),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_data (store_data)
    );

    cpu_execute u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance        (advance),
        .ex_ir          (ex_ir),
        .op_a           (op_a),
        .op_b           (op_b),
        .store_data     (store_data),
        .mem_ir         (mem_ir),
        .alu_result     (alu_result),
        .mem_we         (mem_we),
        .mem_store_data (mem_store_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    cpu_mem_wb u_mem_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .mem_ir     (mem_ir),
        .alu_result (alu_result),
        .d_datain   (d_datain),
        .wb_ir      (wb_ir),
        .wb_en      (wb_en),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data)
    );

    // data memory port driven from the memory stage
    assign d_addr    = alu_result[`CPU_ADDR_WIDTH-1:0];
    assign d_we      = mem_we;
    assign d_dataout = mem_store_data;

endmodule

// ==== tb_checker.sv ====
// pipe_cpu checker
// runs the program on an architectural model to get the expected stores,
// then compares every committed store, the halt state and the run length

`timescale 1ns/100ps

`include "cpu_defines.svh"

module tb_checker
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  addr_t  i_addr,
    input  addr_t  d_addr,
    input  logic   d_we,
    input  word_t  d_dataout,
    input  logic   check_halt,
    input  int     cycle_limit,
    input  instr_t rom_init [1 << `CPU_ADDR_WIDTH],
    input  word_t  ram_init [1 << `CPU_ADDR_WIDTH],
    output int     error_count,
    output bit     timed_out
);

    addr_t exp_addr [$];
    word_t exp_data [$];
    int    idx;
    int    cycles;
    bit    built;
    bit    have_prev;
    bit    halt_seen;
    logic  prev_we;
    addr_t prev_i_addr;
    addr_t prev_addr;
    word_t prev_data;

    // ------------------------------------------------------------------------
    // architectural model with three delay slots after a taken branch
    // ------------------------------------------------------------------------
    function automatic void build_expected();
        word_t      regs [8];
        word_t      dmem [1 << `CPU_ADDR_WIDTH];
        logic       zf;
        logic       nf;
        addr_t      pc;
        addr_t      tgt;
        addr_t      br_tgt;
        addr_t      maddr;
        int         slots;
        int         steps;
        logic       halted;
        logic       taken;
        logic       writes;
        logic       sets;
        instr_t     ir;
        word_t      ra;
        word_t      rb;
        word_t      rc;
        word_t      res;
        logic [7:0] imm;
        logic [3:0] val3;

        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 8; i++)
            regs[i] = '0;
        for (int i = 0; i < (1 << `CPU_ADDR_WIDTH); i++)
            dmem[i] = ram_init[i];
        zf = 1'b0;
        nf = 1'b0;
        pc = '0;
        tgt = '0;
        slots = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < 1000)
        begin
            ir = rom_init[pc];
            ra = regs[ir.r1];
            rb = regs[ir.imm[6:4]];
            rc = regs[ir.imm[2:0]];
            imm = ir.imm;
            val3 = ir.imm[3:0];
            maddr = addr_t'(rb + word_t'(val3));
            br_tgt = addr_t'(ra + word_t'(imm));
            taken = 1'b0;
            res = '0;
            // CMP only updates the flags
            writes = ir.op inside {OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
                                   OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
            sets = ir.op inside {OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI, OP_CMP,
                                 OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
            case (ir.op)
                OP_HALT:  halted = 1'b1;
                OP_LOAD:  res = dmem[maddr];
                OP_STORE:
                begin
                    dmem[maddr] = ra;
                    exp_addr.push_back(maddr);
                    exp_data.push_back(ra);
                end
                OP_LDIH:  res = ra + {imm, 8'h00};
                OP_ADD:   res = rb + rc;
                OP_ADDI:  res = ra + word_t'(imm);
                OP_SUB:   res = rb - rc;
                OP_SUBI:  res = ra - word_t'(imm);
                OP_CMP:   res = rb - rc;
                OP_AND:   res = rb & rc;
                OP_OR:    res = rb | rc;
                OP_XOR:   res = rb ^ rc;
                OP_SLL:   res = rb << val3;
                OP_SRL:   res = rb >> val3;
                OP_JUMP:
                begin
                    taken = 1'b1;
                    br_tgt = imm;
                end
                OP_JMPR:  taken = 1'b1;
                OP_BZ:    taken = zf;
                OP_BNZ:   taken = !zf;
                OP_BN:    taken = nf;
                OP_BNN:   taken = !nf;
                default:  ;
            endcase
            if (writes)
                regs[ir.r1] = res;
            if (sets)
            begin
                zf = (res == '0);
                nf = res[15];
            end
            // after a taken branch run three slots and then the target
            if (taken)
            begin
                tgt = br_tgt;
                slots = 3;
                pc = pc + addr_t'(1);
            end
            else if (slots > 0)
            begin
                slots--;
                pc = (slots == 0) ? tgt : pc + addr_t'(1);
            end
            else
            begin
                pc = pc + addr_t'(1);
            end
            steps++;
        end
        if (!halted)
        begin
            $display("model never reached HALT, program image is broken");
            error_count++;
        end
    endfunction

    task automatic compare_store(addr_t addr, word_t data);
        if (idx >= exp_addr.size())
        begin
            $display("unexpected store to %h at %0t, model has no more stores", addr, $time);
            error_count++;
        end
        else
        begin
            if (addr != exp_addr[idx] || data != exp_data[idx])
            begin
                $display("[ERROR] %0t store %0d got addr %h data %h, expected addr %h data %h",
                         $time, idx, addr, data, exp_addr[idx], exp_data[idx]);
                error_count++;
            end
            idx++;
        end
    endtask

    // ------------------------------------------------------------------------
    // compare process sampled mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit && !timed_out)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            error_count++;
            timed_out = 1'b1;
        end
        if (!rst_n)
        begin
            built = 1'b0;
            idx = 0;
            have_prev = 1'b0;
            halt_seen = 1'b0;
        end
        else
        begin
            if (!built)
            begin
                build_expected();
                built = 1'b1;
            end
            // a store commits when the pipeline moved past it
            if (have_prev && prev_we && (i_addr != prev_i_addr))
                compare_store(prev_addr, prev_data);
            if (check_halt)
            begin
                if (!halt_seen && idx != exp_addr.size())
                begin
                    $display("run halted after %0d of %0d expected stores",
                             idx, exp_addr.size());
                    error_count++;
                end
                if (have_prev && (i_addr != prev_i_addr || d_we))
                begin
                    $display("CPU still active after HALT at %0t", $time);
                    error_count++;
                end
            end
            halt_seen = check_halt;
            prev_we = d_we;
            prev_i_addr = i_addr;
            prev_addr = d_addr;
            prev_data = d_dataout;
            have_prev = 1'b1;
        end
    end

endmodule

// ==== tb_pipe_cpu.sv ====
// pipe_cpu testbench
// clock, reset, instruction ROM and data RAM, LFSR-built program image;
// runs the program once straight through and once with an enable stall

`timescale 1ns/100ps

`include "cpu_defines.svh"

module tb_pipe_cpu
    import cpu_pkg::*;
();

    localparam int MEM_WORDS = 1 << `CPU_ADDR_WIDTH;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   enable;
    logic   start;
    instr_t i_datain;
    word_t  d_datain;
    addr_t  i_addr;
    addr_t  d_addr;
    logic   d_we;
    word_t  d_dataout;
    logic   check_halt;
    int     cycle_limit;
    int     error_count;
    bit     timed_out;

    instr_t      rom [MEM_WORDS];
    word_t       ram [MEM_WORDS];
    word_t       ram_init [MEM_WORDS];
    int          prog_len;
    logic [15:0] lfsr_state;

    pipe_cpu uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .start     (start),
        .i_datain  (i_datain),
        .d_datain  (d_datain),
        .i_addr    (i_addr),
        .d_addr    (d_addr),
        .d_we      (d_we),
        .d_dataout (d_dataout)
    );

    tb_checker chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr      (i_addr),
        .d_addr      (d_addr),
        .d_we        (d_we),
        .d_dataout   (d_dataout),
        .check_halt  (check_halt),
        .cycle_limit (cycle_limit),
        .rom_init    (rom),
        .ram_init    (ram_init),
        .error_count (error_count),
        .timed_out   (timed_out)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // memories
    // ------------------------------------------------------------------------
    assign i_datain = rom[i_addr];
    assign d_datain = ram[d_addr];

    // reloaded from the initial copy while in reset
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                ram[i] <= ram_init[i];
        end
        else if (d_we)
        begin
            ram[d_addr] <= d_dataout;
        end
    end

    // galois LFSR stepped once per bit
    function automatic logic [15:0] lfsr_take(int nbits);
        logic [15:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < nbits; i++)
        begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 16'hB400;
            v = {v[14:0], b};
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // instruction encoding and program image
    // ------------------------------------------------------------------------
    function automatic instr_t enc_ri(opcode_t op, int r1, logic [7:0] imm);
        instr_t ir;
        ir.op = op;
        ir.r1 = reg_idx_t'(r1);
        ir.imm = imm;
        return ir;
    endfunction

    function automatic instr_t enc_rrr(opcode_t op, int r1, int r2, int r3);
        return enc_ri(op, r1, {1'b0, 3'(r2), 1'b0, 3'(r3)});
    endfunction

    function automatic instr_t enc_rv(opcode_t op, int r1, int r2, int v);
        return enc_ri(op, r1, {1'b0, 3'(r2), 4'(v)});
    endfunction

    task automatic emit(instr_t ir);
        rom[prog_len] = ir;
        prog_len++;
    endtask

    // three NOPs so the next reader sees the written register
    task automatic emit_spaced(instr_t ir);
        emit(ir);
        repeat (3) emit(NOP_INSTR);
    endtask

    // CMP r[ra]-r[rb] then a branch over one store with stores in all delay slots
    task automatic branch_case(opcode_t br, int ra, int rb, int off);
        emit(enc_rrr(OP_CMP, 0, ra, rb));
        emit(enc_ri(br, 0, 8'(prog_len + 5)));
        for (int i = 0; i < 4; i++)
            emit(enc_rv(OP_STORE, 6, 7, off + i));
    endtask

    task automatic build_program();
        int v;
        prog_len = 0;
        emit_spaced(enc_ri(OP_ADDI, 7, 8'h80));
        emit_spaced(enc_ri(OP_LDIH, 1, 8'(lfsr_take(8))));
        emit_spaced(enc_ri(OP_ADDI, 1, 8'(lfsr_take(8))));
        emit_spaced(enc_ri(OP_LDIH, 2, 8'(lfsr_take(8))));
        emit_spaced(enc_ri(OP_ADDI, 2, 8'(lfsr_take(8))));
        emit_spaced(enc_rrr(OP_ADD, 3, 1, 2));
        emit(enc_rv(OP_STORE, 3, 7, 0));
        emit_spaced(enc_rrr(OP_SUB, 3, 1, 2));
        emit(enc_rv(OP_STORE, 3, 7, 1));
        emit_spaced(enc_rrr(OP_AND, 3, 1, 2));
        emit(enc_rv(OP_STORE, 3, 7, 2));
        emit_spaced(enc_rrr(OP_OR, 3, 1, 2));
        emit(enc_rv(OP_STORE, 3, 7, 3));
        emit_spaced(enc_rrr(OP_XOR, 3, 1, 2));
        emit(enc_rv(OP_STORE, 3, 7, 4));
        emit_spaced(enc_rv(OP_SLL, 3, 1, int'(lfsr_take(4))));
        emit(enc_rv(OP_STORE, 3, 7, 5));
        emit_spaced(enc_rv(OP_SRL, 3, 2, int'(lfsr_take(4))));
        emit(enc_rv(OP_STORE, 3, 7, 6));
        emit(enc_rv(OP_STORE, 1, 7, 7));
        emit(enc_rv(OP_STORE, 2, 7, 8));
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        // loads from the seeded low words
        emit_spaced(enc_rv(OP_LOAD, 4, 0, int'(lfsr_take(4))));
        emit_spaced(enc_rv(OP_LOAD, 5, 0, int'(lfsr_take(4))));
        emit_spaced(enc_rrr(OP_ADD, 3, 4, 5));
        emit(enc_rv(OP_STORE, 3, 7, 0));
        emit_spaced(enc_ri(OP_SUBI, 4, 8'(lfsr_take(8))));
        emit(enc_rv(OP_STORE, 4, 7, 1));
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        // r6 = 5 against r0 = 0 gives zero, positive and negative
        emit_spaced(enc_ri(OP_ADDI, 6, 8'd5));
        branch_case(OP_BZ, 6, 6, 0);
        branch_case(OP_BZ, 6, 0, 4);
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        branch_case(OP_BNZ, 6, 0, 0);
        branch_case(OP_BNZ, 6, 6, 4);
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        branch_case(OP_BN, 0, 6, 0);
        branch_case(OP_BN, 6, 0, 4);
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        branch_case(OP_BNN, 6, 0, 0);
        branch_case(OP_BNN, 0, 6, 4);
        emit_spaced(enc_ri(OP_ADDI, 7, 8'd16));
        // JUMP and then JMPR through a register offset
        emit(enc_ri(OP_JUMP, 0, 8'(prog_len + 5)));
        emit(enc_rv(OP_STORE, 6, 7, 0));
        emit(NOP_INSTR);
        emit(NOP_INSTR);
        emit(enc_rv(OP_STORE, 6, 7, 1));
        emit(enc_rv(OP_STORE, 6, 7, 2));
        v = int'(lfsr_take(3));
        emit_spaced(enc_rrr(OP_SUB, 5, 5, 5));
        emit_spaced(enc_ri(OP_ADDI, 5, 8'(v)));
        emit(enc_ri(OP_JMPR, 5, 8'(prog_len + 5 - v)));
        emit(enc_rv(OP_STORE, 6, 7, 3));
        emit(NOP_INSTR);
        emit(NOP_INSTR);
        emit(enc_rv(OP_STORE, 6, 7, 4));
        emit(enc_rv(OP_STORE, 6, 7, 5));
        emit(enc_rv(OP_STORE, 1, 7, 6));
        emit(enc_ri(OP_HALT, 0, 8'h00));
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic run_program(bit stall);
        int    stable;
        addr_t prev;
        rst_n = 1'b0;
        enable = 1'b0;
        start = 1'b0;
        repeat (5) next_cycle();
        rst_n = 1'b1;
        enable = 1'b1;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        if (stall)
        begin
            repeat (40) next_cycle();
            enable = 1'b0;
            repeat (6) next_cycle();
            enable = 1'b1;
            next_cycle();
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        // halted once the PC stops moving
        stable = 0;
        prev = i_addr;
        while (stable < 3)
        begin
            next_cycle();
            if (i_addr == prev)
                stable++;
            else
                stable = 0;
            prev = i_addr;
        end
        check_halt = 1'b1;
        repeat (8) next_cycle();
        check_halt = 1'b0;
    endtask

    task automatic finish_run();
        $display("error count: %0d", error_count);
        if (error_count == 0 && !timed_out)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    initial
    begin
        @(posedge timed_out);
        finish_run();
    end

    initial
    begin
        rst_n = 1'b0;
        enable = 1'b0;
        start = 1'b0;
        check_halt = 1'b0;
        lfsr_state = 16'd10;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            rom[i] = NOP_INSTR;
            ram_init[i] = lfsr_take(16);
        end
        build_program();
        // two runs of the same program
        cycle_limit = 4 * (2 * prog_len) + 200;
        run_program(1'b0);
        run_program(1'b1);
        finish_run();
    end

endmodule

// ==== pipe_cpu.f ====
+incdir+.
cpu_pkg.sv
cpu_run_control.sv
cpu_fetch.sv
cpu_reg_file.sv
cpu_decode.sv
cpu_execute.sv
cpu_mem_wb.sv
pipe_cpu.sv
tb_checker.sv
tb_pipe_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pipe_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pipe_cpu \
    -f pipe_cpu.f -o sim_pipe_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_pipe_cpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation did not run to completion"
    exit 1
fi

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1
